// ==== list.f ====
proc_pkg.sv
proc_alu.sv
proc_dpath.sv
proc_ctrl.sv
proc_mngr_link.sv
proc_mem.sv
proc_top.sv
tb_proc.sv

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_proc -f list.f

out=$(./obj_dir/Vtb_proc)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'NO ERRORS'

// ==== tb_proc.sv ====
/*
  Directed testbench for the five-stage core
  Programs start at the reset vector and end in a jal-to-self loop; data stays below 0x200
  The register file is not reset, so every program sets the registers it reads
*/
`timescale 1ns/1ns

module tb_proc;
  import proc_pkg::*;

  localparam int c_clk_period      = 20;
  localparam int c_reset_cycles    = 5;
  localparam int c_mem_words       = 256;
  localparam int c_num_tests       = 6;
  localparam int c_cycles_per_test = 2000;
  localparam int c_quiet_cycles    = 40;
  localparam int c_echo_words      = 16;
  localparam int c_marker          = 32'h66;
  // csrw at index 5 cannot reach the link earlier than this
  localparam int c_first_out_cycles = 8;

  logic  clk;
  logic  reset;
  logic  load_en;
  word_t load_addr;
  word_t load_data;
  logic  in_req;
  word_t in_data;
  logic  in_ack;
  logic  out_req;
  word_t out_data;
  logic  out_ack;

  word_t prog[$];
  word_t data_addr_q[$];
  word_t data_val_q[$];
  word_t exp_q[$];
  word_t rand_state;
  int    error_count;
  int    check_count;
  int    test_count;
  int    errors_at_start;
  int    rx_count;

  proc_top #(
    .mem_words (c_mem_words)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_data  (out_data),
    .out_ack   (out_ack)
  );

  initial begin
    clk = 1'b0;
  end

  always #(c_clk_period / 2) clk = ~clk;

  // Each rising out_req starts one output word
  always @(posedge out_req) begin
    rx_count++;
  end

  // ----------------------------------------
  // Instruction encoders, RV32 formats
  // ----------------------------------------

  function automatic word_t r_inst(input logic [6:0] funct7, input logic [2:0] funct3,
                                   input int rd, input int rs1, input int rs2);
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], opc_op};
  endfunction

  function automatic word_t add_inst(input int rd, input int rs1, input int rs2);
    return r_inst(7'b0000000, 3'b000, rd, rs1, rs2);
  endfunction

  function automatic word_t sub_inst(input int rd, input int rs1, input int rs2);
    return r_inst(7'b0100000, 3'b000, rd, rs1, rs2);
  endfunction

  function automatic word_t and_inst(input int rd, input int rs1, input int rs2);
    return r_inst(7'b0000000, 3'b111, rd, rs1, rs2);
  endfunction

  function automatic word_t or_inst(input int rd, input int rs1, input int rs2);
    return r_inst(7'b0000000, 3'b110, rd, rs1, rs2);
  endfunction

  function automatic word_t slt_inst(input int rd, input int rs1, input int rs2);
    return r_inst(7'b0000000, 3'b010, rd, rs1, rs2);
  endfunction

  function automatic word_t addi_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], opc_op_imm};
  endfunction

  function automatic word_t lw_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], opc_load};
  endfunction

  function automatic word_t sw_inst(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
  endfunction

  // Offsets are in bytes from the branch itself
  function automatic word_t bne_inst(input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], opc_branch};
  endfunction

  function automatic word_t jal_inst(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
  endfunction

  function automatic word_t csrr_inst(input int rd);
    return {12'hfc0, 5'd0, 3'b010, rd[4:0], opc_system};
  endfunction

  function automatic word_t csrw_inst(input int rs1);
    return {12'h7c0, rs1[4:0], 3'b001, 5'd0, opc_system};
  endfunction

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic word_t lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Drive and sample point, 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic new_program();
    prog.delete();
    data_addr_q.delete();
    data_val_q.delete();
    exp_q.delete();
  endtask

  task automatic put_inst(input word_t inst);
    prog.push_back(inst);
  endtask

  task automatic put_data(input word_t addr, input word_t data);
    data_addr_q.push_back(addr);
    data_val_q.push_back(data);
  endtask

  task automatic reset_cycle();
    next_cycle();
    check_bit(in_ack, 1'b0, "in_ack during reset");
    check_bit(out_req, 1'b0, "out_req during reset");
  endtask

  // Reset stays high for the load and then at least 5 more cycles
  task automatic load_and_reset();
    reset   = 1'b1;
    out_ack = 1'b0;
    load_en = 1'b1;
    foreach (data_addr_q[i]) begin
      load_addr = data_addr_q[i];
      load_data = data_val_q[i];
      reset_cycle();
    end
    foreach (prog[i]) begin
      load_addr = c_reset_vector + word_t'(4 * i);
      load_data = prog[i];
      reset_cycle();
    end
    load_en = 1'b0;
    repeat (c_reset_cycles) begin
      reset_cycle();
    end
    reset = 1'b0;
  endtask

  task automatic drive_input(input word_t data, input int gap);
    repeat (gap) begin
      next_cycle();
    end
    in_data = data;
    in_req  = 1'b1;
    while (!in_ack) begin
      next_cycle();
    end
    in_req = 1'b0;
    while (in_ack) begin
      next_cycle();
    end
  endtask

  task automatic receive_output(output word_t data);
    int delay;
    while (!out_req) begin
      next_cycle();
    end
    data  = out_data;
    delay = int'(lcg_next() % 32'd6);
    repeat (delay) begin
      next_cycle();
    end
    out_ack = 1'b1;
    while (out_req) begin
      next_cycle();
    end
    out_ack = 1'b0;
  endtask

  // Expected words in order, then a quiet window with no further output
  task automatic collect_outputs();
    word_t got;
    logic  extra;
    extra = 1'b0;
    foreach (exp_q[i]) begin
      receive_output(got);
      check_word(got, exp_q[i], $sformatf("output word %0d", i));
    end
    repeat (c_quiet_cycles) begin
      next_cycle();
      if (out_req) begin
        extra = 1'b1;
      end
    end
    check_bit(extra, 1'b0, "unexpected extra output word");
  endtask

  task automatic start_test();
    errors_at_start = error_count;
    rx_count        = 0;
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = error_count - errors_at_start;
    test_count++;
    if (errs == 0) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, errs);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic arithmetic_test();
    word_t a;
    word_t b;
    start_test();
    new_program();
    a = 32'd100;
    b = -32'd37;
    put_inst(addi_inst(1, 0, 100));
    put_inst(addi_inst(2, 0, -37));
    put_inst(add_inst(3, 1, 2));
    put_inst(sub_inst(4, 2, 1));
    put_inst(and_inst(5, 1, 2));
    put_inst(or_inst(6, 1, 2));
    put_inst(slt_inst(7, 2, 1));
    put_inst(slt_inst(8, 1, 2));
    put_inst(addi_inst(9, 1, 2047));
    for (int r = 1; r <= 9; r++) begin
      put_inst(csrw_inst(r));
    end
    put_inst(jal_inst(0, 0));
    exp_q.push_back(a);
    exp_q.push_back(b);
    exp_q.push_back(a + b);
    exp_q.push_back(b - a);
    exp_q.push_back(a & b);
    exp_q.push_back(a | b);
    exp_q.push_back(($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    exp_q.push_back(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    exp_q.push_back(a + 32'd2047);
    load_and_reset();
    collect_outputs();
    report_test("arithmetic");
  endtask

  task automatic dependence_test();
    word_t r1;
    word_t r2;
    word_t r3;
    word_t r4;
    word_t r5;
    word_t r6;
    word_t r7;
    start_test();
    new_program();
    put_inst(addi_inst(1, 0, 5));
    put_inst(addi_inst(1, 1, 3));
    put_inst(add_inst(2, 1, 1));
    put_inst(sub_inst(3, 2, 1));
    put_inst(addi_inst(0, 3, 77));
    put_inst(add_inst(4, 0, 3));
    put_inst(or_inst(5, 4, 2));
    put_inst(add_inst(0, 5, 5));
    put_inst(csrw_inst(0));
    put_inst(csrw_inst(3));
    put_inst(csrw_inst(4));
    put_inst(csrw_inst(5));
    put_inst(slt_inst(6, 0, 5));
    put_inst(csrw_inst(6));
    put_inst(addi_inst(7, 5, -30));
    put_inst(csrw_inst(7));
    put_inst(jal_inst(0, 0));
    // Sequential model, x0 writes dropped
    r1 = 32'd5;
    r1 = r1 + 32'd3;
    r2 = r1 + r1;
    r3 = r2 - r1;
    r4 = r3;
    r5 = r4 | r2;
    r6 = ($signed(32'd0) < $signed(r5)) ? 32'd1 : 32'd0;
    r7 = r5 - 32'd30;
    exp_q.push_back(32'd0);
    exp_q.push_back(r3);
    exp_q.push_back(r4);
    exp_q.push_back(r5);
    exp_q.push_back(r6);
    exp_q.push_back(r7);
    load_and_reset();
    collect_outputs();
    report_test("dependences");
  endtask

  task automatic memory_test();
    word_t pa;
    word_t pb;
    word_t pc;
    start_test();
    new_program();
    pa = lcg_next();
    pb = lcg_next();
    pc = lcg_next();
    put_data(32'h100, pa);
    put_data(32'h104, pb);
    put_data(32'h180, pc);
    put_inst(addi_inst(1, 0, 64));
    put_inst(addi_inst(2, 0, 1234));
    put_inst(addi_inst(3, 0, -1));
    put_inst(sw_inst(2, 1, 0));
    put_inst(sw_inst(3, 1, 8));
    put_inst(sw_inst(1, 1, -4));
    // Store then load of the same word back to back
    put_inst(sw_inst(3, 1, 4));
    put_inst(lw_inst(10, 1, 4));
    put_inst(csrw_inst(10));
    put_inst(lw_inst(4, 1, 0));
    put_inst(lw_inst(5, 1, 8));
    put_inst(lw_inst(6, 1, -4));
    put_inst(csrw_inst(4));
    put_inst(csrw_inst(5));
    put_inst(csrw_inst(6));
    put_inst(lw_inst(7, 0, 32'h100));
    put_inst(lw_inst(8, 0, 32'h104));
    put_inst(lw_inst(9, 0, 32'h180));
    put_inst(csrw_inst(7));
    put_inst(csrw_inst(8));
    put_inst(csrw_inst(9));
    put_inst(jal_inst(0, 0));
    exp_q.push_back(32'hffff_ffff);
    exp_q.push_back(32'd1234);
    exp_q.push_back(32'hffff_ffff);
    exp_q.push_back(32'd64);
    exp_q.push_back(pa);
    exp_q.push_back(pb);
    exp_q.push_back(pc);
    load_and_reset();
    collect_outputs();
    report_test("memory");
  endtask

  task automatic control_flow_test();
    word_t link;
    start_test();
    new_program();
    put_inst(addi_inst(1, 0, 7));
    put_inst(addi_inst(2, 0, 7));
    put_inst(addi_inst(3, 0, 9));
    put_inst(addi_inst(4, 0, c_marker));
    // Equal operands, so this falls through
    put_inst(bne_inst(1, 2, 8));
    put_inst(addi_inst(5, 0, 1));
    put_inst(csrw_inst(5));
    put_inst(bne_inst(1, 3, 12));
    put_inst(csrw_inst(4));
    put_inst(csrw_inst(4));
    put_inst(addi_inst(6, 0, 2));
    put_inst(csrw_inst(6));
    link = c_reset_vector + word_t'(4 * prog.size()) + 32'd4;
    put_inst(jal_inst(7, 12));
    put_inst(csrw_inst(4));
    put_inst(csrw_inst(4));
    put_inst(csrw_inst(7));
    // Countdown loop with a backward bne
    put_inst(addi_inst(8, 0, 3));
    put_inst(addi_inst(8, 8, -1));
    put_inst(csrw_inst(8));
    put_inst(bne_inst(8, 0, -8));
    put_inst(jal_inst(0, 0));
    exp_q.push_back(32'd1);
    exp_q.push_back(32'd2);
    exp_q.push_back(link);
    exp_q.push_back(32'd2);
    exp_q.push_back(32'd1);
    exp_q.push_back(32'd0);
    load_and_reset();
    collect_outputs();
    report_test("control flow");
  endtask

  task automatic echo_test();
    word_t in_words[$];
    int    gaps[$];
    word_t w;
    start_test();
    new_program();
    put_inst(csrr_inst(1));
    put_inst(addi_inst(2, 1, 1));
    put_inst(csrw_inst(2));
    put_inst(jal_inst(0, -12));
    for (int i = 0; i < c_echo_words; i++) begin
      w = lcg_next();
      in_words.push_back(w);
      gaps.push_back(int'(lcg_next() % 32'd4));
      exp_q.push_back(w + 32'd1);
    end
    load_and_reset();
    fork
      begin
        foreach (in_words[i]) begin
          drive_input(in_words[i], gaps[i]);
        end
      end
      collect_outputs();
    join
    check_word(word_t'(rx_count), word_t'(in_words.size()), "output word count");
    report_test("manager echo");
  endtask

  task automatic reset_test();
    start_test();
    new_program();
    put_inst(addi_inst(5, 0, 32'h5a));
    put_inst(addi_inst(6, 0, 1));
    put_inst(addi_inst(7, 0, 2));
    put_inst(addi_inst(8, 0, 3));
    put_inst(addi_inst(9, 0, 4));
    put_inst(csrw_inst(5));
    put_inst(jal_inst(0, 0));
    exp_q.push_back(32'h5a);
    // A pending request during reset must not be acknowledged
    in_data = 32'hdead_beef;
    in_req  = 1'b1;
    load_and_reset();
    in_req = 1'b0;
    repeat (c_first_out_cycles) begin
      next_cycle();
      check_bit(in_ack, 1'b0, "in_ack after reset");
      check_bit(out_req, 1'b0, "out_req before first csrw");
    end
    collect_outputs();
    report_test("reset");
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------

  initial begin
    reset           = 1'b1;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    in_req          = 1'b0;
    in_data         = '0;
    out_ack         = 1'b0;
    rand_state      = 32'hfd63_c8e8;
    error_count     = 0;
    check_count     = 0;
    test_count      = 0;
    errors_at_start = 0;
    rx_count        = 0;
    arithmetic_test();
    dependence_test();
    memory_test();
    control_flow_test();
    echo_test();
    reset_test();
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (c_num_tests * c_cycles_per_test) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles",
             c_num_tests * c_cycles_per_test);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== proc_top.sv ====
/*
  Core top level with pipeline, shared memory and manager link
  Load the program only while reset is held
*/
`timescale 1ns/1ns

module proc_top #(
  parameter int mem_words = 256
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            load_en,
  input  proc_pkg::word_t load_addr,
  input  proc_pkg::word_t load_data,
  input  logic            in_req,
  input  proc_pkg::word_t in_data,
  output logic            in_ack,
  output logic            out_req,
  output proc_pkg::word_t out_data,
  input  logic            out_ack
);
  import proc_pkg::*;

  // Control to datapath
  logic       reg_en_f;
  logic       reg_en_d;
  logic       reg_en_x;
  logic       reg_en_m;
  logic       reg_en_w;
  pc_sel_e    pc_sel;
  op2_sel_e   op2_sel;
  imm_sel_e   imm_sel;
  alu_fn_e    alu_fn;
  logic       wb_mem_sel;
  logic       rf_wen_w;
  logic [4:0] rf_waddr_w;
  logic       dmem_wen_m;

  // Datapath status and memory buses
  word_t      inst_d;
  logic       br_taken_x;
  word_t      wb_data;
  word_t      fetch_addr;
  word_t      fetch_data;
  word_t      dmem_addr;
  word_t      dmem_wdata;
  word_t      dmem_rdata;

  // Manager link side
  logic       mngr_take;
  logic       mngr_full;
  logic       mngr_busy;
  logic       mngr_send;
  word_t      mngr_data;

  proc_dpath dpath (.*);

  proc_ctrl ctrl (.*);

  proc_mngr_link link (
    .send_data (wb_data),
    .*
  );

  proc_mem #(
    .mem_words (mem_words)
  ) mem (
    .dmem_wen (dmem_wen_m),
    .*
  );

endmodule

// ==== proc_mem.sv ====
/*
  Shared instruction and data memory, word addressed, reads combinational
  mem_words must be a power of two and at least 2; addresses wrap
*/
`timescale 1ns/1ns

module proc_mem #(
  parameter int mem_words = 256
) (
  input  logic            clk,
  input  proc_pkg::word_t fetch_addr,
  output proc_pkg::word_t fetch_data,
  input  proc_pkg::word_t dmem_addr,
  input  proc_pkg::word_t dmem_wdata,
  input  logic            dmem_wen,
  output proc_pkg::word_t dmem_rdata,
  input  logic            load_en,
  input  proc_pkg::word_t load_addr,
  input  proc_pkg::word_t load_data
);
  import proc_pkg::*;

  localparam int idx_w = $clog2(mem_words);

  word_t mem [mem_words];

  assign fetch_data = mem[fetch_addr[idx_w+1:2]];
  assign dmem_rdata = mem[dmem_addr[idx_w+1:2]];

  // Load port wins over a store in the same cycle
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr[idx_w+1:2]] <= load_data;
    end else if (dmem_wen) begin
      mem[dmem_addr[idx_w+1:2]] <= dmem_wdata;
    end
  end

endmodule

// ==== proc_mngr_link.sv ====
/*
  Four-phase req/ack endpoints for the manager words
  One input word is held at a time; one output word is in flight at a time
*/
`timescale 1ns/1ns

module proc_mngr_link (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_req,
  input  proc_pkg::word_t in_data,
  output logic            in_ack,
  input  logic            mngr_take,
  output logic            mngr_full,
  output proc_pkg::word_t mngr_data,
  input  logic            mngr_send,
  input  proc_pkg::word_t send_data,
  output logic            mngr_busy,
  output logic            out_req,
  output proc_pkg::word_t out_data,
  input  logic            out_ack
);

  typedef enum logic {
    in_idle,
    in_acked
  } in_state_e;

  typedef enum logic [1:0] {
    out_idle,
    out_wait_ack,
    out_wait_drop
  } out_state_e;

  in_state_e  in_state;
  out_state_e out_state;
  logic       in_capture;
  logic       out_capture;

  assign in_capture  = (in_state == in_idle) && in_req && !mngr_full;
  assign out_capture = (out_state == out_idle) && mngr_send;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_state  <= in_idle;
      mngr_full <= 1'b0;
      out_state <= out_idle;
    end else begin
      if (mngr_take) begin
        mngr_full <= 1'b0;
      end
      // Input side holds ack until the source drops req
      case (in_state)
        in_idle: begin
          if (in_capture) begin
            in_state  <= in_acked;
            mngr_full <= 1'b1;
          end
        end
        default: begin
          if (!in_req) begin
            in_state <= in_idle;
          end
        end
      endcase
      // Output side stays busy until ack has fallen again
      case (out_state)
        out_idle: begin
          if (out_capture) begin
            out_state <= out_wait_ack;
          end
        end
        out_wait_ack: begin
          if (out_ack) begin
            out_state <= out_wait_drop;
          end
        end
        default: begin
          if (!out_ack) begin
            out_state <= out_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_capture) begin
      mngr_data <= in_data;
    end
    if (out_capture) begin
      out_data <= send_data;
    end
  end

  assign in_ack    = (in_state == in_acked);
  assign out_req   = (out_state == out_wait_ack);
  assign mngr_busy = (out_state != out_idle);

endmodule

// ==== proc_ctrl.sv ====
/*
  Pipeline control with stall-only hazard handling
  Manager CSRs are 0xfc0 for csrr and 0x7c0 for csrw; other CSRs decode as nops
*/
`timescale 1ns/1ns

module proc_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  proc_pkg::word_t    inst_d,
  input  logic               br_taken_x,
  input  logic               mngr_full,
  input  logic               mngr_busy,
  output logic               reg_en_f,
  output logic               reg_en_d,
  output logic               reg_en_x,
  output logic               reg_en_m,
  output logic               reg_en_w,
  output proc_pkg::pc_sel_e  pc_sel,
  output proc_pkg::op2_sel_e op2_sel,
  output proc_pkg::imm_sel_e imm_sel,
  output proc_pkg::alu_fn_e  alu_fn,
  output logic               wb_mem_sel,
  output logic               rf_wen_w,
  output logic [4:0]         rf_waddr_w,
  output logic               dmem_wen_m,
  output logic               mngr_take,
  output logic               mngr_send
);
  import proc_pkg::*;

  localparam logic [11:0] c_csr_mngr_in  = 12'hfc0;
  localparam logic [11:0] c_csr_mngr_out = 12'h7c0;

  logic [4:0]  rs1_d;
  logic [4:0]  rs2_d;
  logic [4:0]  rd_d;
  logic [2:0]  funct3_d;
  logic [6:0]  funct7_d;
  logic [11:0] csr_d;
  logic        use_rs1_d;
  logic        use_rs2_d;
  logic        writes_d;
  logic        load_d;
  logic        store_d;
  logic        bne_d;
  logic        jal_d;
  logic        csrr_d;
  logic        csrw_d;
  alu_fn_e     alu_fn_d;
  alu_fn_e     alu_fn_x;
  logic        val_d;
  logic        val_x;
  logic        val_m;
  logic        val_w;
  logic        wen_x;
  logic        wen_m;
  logic        wen_w;
  logic [4:0]  rd_x;
  logic [4:0]  rd_m;
  logic [4:0]  rd_w;
  logic        load_x;
  logic        load_m;
  logic        store_x;
  logic        store_m;
  logic        bne_x;
  logic        csrw_x;
  logic        csrw_m;
  logic        csrw_w;
  logic        raw_hazard;
  logic        stall_d;
  logic        squash_x;
  logic        freeze;
  logic        go_x;

  assign rs1_d    = inst_d[19:15];
  assign rs2_d    = inst_d[24:20];
  assign rd_d     = inst_d[11:7];
  assign funct3_d = inst_d[14:12];
  assign funct7_d = inst_d[31:25];
  assign csr_d    = inst_d[31:20];

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  always_comb begin
    use_rs1_d = 1'b0;
    use_rs2_d = 1'b0;
    writes_d  = 1'b0;
    load_d    = 1'b0;
    store_d   = 1'b0;
    bne_d     = 1'b0;
    jal_d     = 1'b0;
    csrr_d    = 1'b0;
    csrw_d    = 1'b0;
    alu_fn_d  = alu_add;
    op2_sel   = op2_rf;
    imm_sel   = imm_i;
    case (opcode_e'(inst_d[6:0]))
      opc_op: begin
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        writes_d  = 1'b1;
        case ({funct7_d, funct3_d})
          10'b0000000_000: alu_fn_d = alu_add;
          10'b0100000_000: alu_fn_d = alu_sub;
          10'b0000000_010: alu_fn_d = alu_slt;
          10'b0000000_110: alu_fn_d = alu_or;
          10'b0000000_111: alu_fn_d = alu_and;
          default:         writes_d = 1'b0;
        endcase
      end
      opc_op_imm: begin
        use_rs1_d = 1'b1;
        writes_d  = (funct3_d == 3'b000);
        op2_sel   = op2_imm;
      end
      opc_load: begin
        use_rs1_d = 1'b1;
        writes_d  = (funct3_d == 3'b010);
        load_d    = (funct3_d == 3'b010);
        op2_sel   = op2_imm;
      end
      opc_store: begin
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        store_d   = (funct3_d == 3'b010);
        op2_sel   = op2_imm;
        imm_sel   = imm_s;
      end
      opc_branch: begin
        use_rs1_d = 1'b1;
        use_rs2_d = 1'b1;
        bne_d     = (funct3_d == 3'b001);
        imm_sel   = imm_b;
        alu_fn_d  = alu_sub;
      end
      opc_jal: begin
        writes_d = 1'b1;
        jal_d    = 1'b1;
        imm_sel  = imm_j;
        alu_fn_d = alu_pass_b;
      end
      opc_system: begin
        if (funct3_d == 3'b010 && csr_d == c_csr_mngr_in) begin
          csrr_d   = 1'b1;
          writes_d = 1'b1;
          op2_sel  = op2_mngr;
          alu_fn_d = alu_pass_b;
        end else if (funct3_d == 3'b001 && csr_d == c_csr_mngr_out) begin
          // rs2 field is csr[4:0] which is zero so op2 reads x0
          csrw_d    = 1'b1;
          use_rs1_d = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  // ----------------------------------------
  // Hazards and stage enables
  // ----------------------------------------

  // Writes to x0 never set a stage wen bit so x0 never stalls
  assign raw_hazard =
      (use_rs1_d && ((val_x && wen_x && rd_x == rs1_d) ||
                     (val_m && wen_m && rd_m == rs1_d) ||
                     (val_w && wen_w && rd_w == rs1_d))) ||
      (use_rs2_d && ((val_x && wen_x && rd_x == rs2_d) ||
                     (val_m && wen_m && rd_m == rs2_d) ||
                     (val_w && wen_w && rd_w == rs2_d)));

  assign freeze   = val_w && csrw_w && mngr_busy;
  assign squash_x = val_x && bne_x && br_taken_x;
  assign stall_d  = val_d && (raw_hazard || (csrr_d && !mngr_full));
  assign go_x     = val_d && !stall_d && !squash_x;

  // Taken branch overrides a decode stall so the target still loads
  assign reg_en_f = !freeze && (!stall_d || squash_x);
  assign reg_en_d = reg_en_f;
  assign reg_en_x = !freeze;
  assign reg_en_m = !freeze;
  assign reg_en_w = !freeze;

  always_comb begin
    if (squash_x) begin
      pc_sel = pc_branch;
    end else if (val_d && jal_d) begin
      pc_sel = pc_jal;
    end else begin
      pc_sel = pc_plus4;
    end
  end

  assign alu_fn     = alu_fn_x;
  assign wb_mem_sel = load_m;
  assign dmem_wen_m = val_m && store_m;
  assign rf_wen_w   = val_w && wen_w;
  assign rf_waddr_w = rd_w;
  assign mngr_take  = go_x && csrr_d && !freeze;
  assign mngr_send  = val_w && csrw_w && !mngr_busy;

  // ----------------------------------------
  // Stage registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      if (reg_en_d) begin
        val_d <= 1'b1;
      end
      if (reg_en_x) begin
        val_x <= go_x;
        val_m <= val_x;
        val_w <= val_m;
      end
    end
  end

  // Per-instruction controls ride alongside the valid bits
  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      wen_x    <= writes_d && (rd_d != 5'd0);
      rd_x     <= rd_d;
      alu_fn_x <= alu_fn_d;
      load_x   <= load_d;
      store_x  <= store_d;
      bne_x    <= bne_d;
      csrw_x   <= csrw_d;
      wen_m    <= wen_x;
      rd_m     <= rd_x;
      load_m   <= load_x;
      store_m  <= store_x;
      csrw_m   <= csrw_x;
      wen_w    <= wen_m;
      rd_w     <= rd_m;
      csrw_w   <= csrw_m;
    end
  end

endmodule

// ==== proc_dpath.sv ====
/*
  Five-stage datapath with no bypass paths; ctrl must stall on every RAW hazard
  Fetch and data memory reads are combinational
*/
`timescale 1ns/1ns

module proc_dpath (
  input  logic               clk,
  input  logic               reset,
  input  logic               reg_en_f,
  input  logic               reg_en_d,
  input  logic               reg_en_x,
  input  logic               reg_en_m,
  input  logic               reg_en_w,
  input  proc_pkg::pc_sel_e  pc_sel,
  input  proc_pkg::op2_sel_e op2_sel,
  input  proc_pkg::imm_sel_e imm_sel,
  input  proc_pkg::alu_fn_e  alu_fn,
  input  logic               wb_mem_sel,
  input  logic               rf_wen_w,
  input  logic [4:0]         rf_waddr_w,
  input  proc_pkg::word_t    mngr_data,
  output proc_pkg::word_t    fetch_addr,
  input  proc_pkg::word_t    fetch_data,
  output proc_pkg::word_t    dmem_addr,
  output proc_pkg::word_t    dmem_wdata,
  input  proc_pkg::word_t    dmem_rdata,
  output proc_pkg::word_t    inst_d,
  output logic               br_taken_x,
  output proc_pkg::word_t    wb_data
);
  import proc_pkg::*;

  word_t      pc_f;
  word_t      pc_next;
  word_t      pc_d;
  word_t      jal_target_d;
  word_t      imm_d;
  word_t      op2_d;
  word_t      rf_rdata1_d;
  word_t      rf_rdata2_d;
  logic [4:0] rs1_d;
  logic [4:0] rs2_d;
  word_t      rf [0:31];
  word_t      op1_x;
  word_t      op2_x;
  word_t      sd_x;
  word_t      br_target_x;
  word_t      alu_result_x;
  word_t      ex_result_m;
  word_t      sd_m;
  word_t      wb_m;
  word_t      wb_w;

  // ----------------------------------------
  // Fetch
  // ----------------------------------------

  always_comb begin
    case (pc_sel)
      pc_branch: pc_next = br_target_x;
      pc_jal:    pc_next = jal_target_d;
      default:   pc_next = pc_f + 32'd4;
    endcase
  end

  // One below the vector so the first fetch lands on it
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= c_reset_vector - 32'd4;
    end else if (reg_en_f) begin
      pc_f <= pc_next;
    end
  end

  assign fetch_addr = pc_next;

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      pc_d   <= pc_next;
      inst_d <= fetch_data;
    end
  end

  assign rs1_d = inst_d[19:15];
  assign rs2_d = inst_d[24:20];

  // x0 reads as zero whatever was written
  assign rf_rdata1_d = (rs1_d == 5'd0) ? '0 : rf[rs1_d];
  assign rf_rdata2_d = (rs2_d == 5'd0) ? '0 : rf[rs2_d];

  always_ff @(posedge clk) begin
    if (rf_wen_w) begin
      rf[rf_waddr_w] <= wb_w;
    end
  end

  always_comb begin
    case (imm_sel)
      imm_s:   imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      imm_b:   imm_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
      imm_j:   imm_d = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
      default: imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  // Same adder gives the jal target and the bne target
  assign jal_target_d = pc_d + imm_d;

  always_comb begin
    case (op2_sel)
      op2_imm:  op2_d = imm_d;
      op2_mngr: op2_d = mngr_data;
      default:  op2_d = rf_rdata2_d;
    endcase
    // jal carries its link address down the op2 path
    if (pc_sel == pc_jal) begin
      op2_d = pc_d + 32'd4;
    end
  end

  // ----------------------------------------
  // Execute
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      op1_x       <= rf_rdata1_d;
      op2_x       <= op2_d;
      sd_x        <= rf_rdata2_d;
      br_target_x <= jal_target_d;
    end
  end

  proc_alu alu (
    .in_a   (op1_x),
    .in_b   (op2_x),
    .fn     (alu_fn),
    .result (alu_result_x),
    .ops_ne (br_taken_x)
  );

  // ----------------------------------------
  // Memory and writeback
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reg_en_m) begin
      ex_result_m <= alu_result_x;
      sd_m        <= sd_x;
    end
  end

  assign dmem_addr  = ex_result_m;
  assign dmem_wdata = sd_m;
  assign wb_m       = wb_mem_sel ? dmem_rdata : ex_result_m;

  always_ff @(posedge clk) begin
    if (reg_en_w) begin
      wb_w <= wb_m;
    end
  end

  assign wb_data = wb_w;

endmodule

// ==== proc_alu.sv ====
/*
  Combinational ALU for the execute stage
  slt is a signed compare; ops_ne feeds the bne decision
*/
`timescale 1ns/1ns

module proc_alu (
  input  proc_pkg::word_t   in_a,
  input  proc_pkg::word_t   in_b,
  input  proc_pkg::alu_fn_e fn,
  output proc_pkg::word_t   result,
  output logic              ops_ne
);
  import proc_pkg::*;

  always_comb begin
    case (fn)
      alu_add:    result = in_a + in_b;
      alu_sub:    result = in_a - in_b;
      alu_and:    result = in_a & in_b;
      alu_or:     result = in_a | in_b;
      alu_slt:    result = {31'd0, $signed(in_a) < $signed(in_b)};
      alu_pass_b: result = in_b;
      default:    result = in_a + in_b;
    endcase
  end

  // Branch compare works on the raw operands
  assign ops_ne = (in_a != in_b);

endmodule

// ==== proc_pkg.sv ====
/*
  Types shared by the core and its testbench
  Opcode values follow the standard RV32 major opcode map
*/
package proc_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes of the kept instructions
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_pass_b
  } alu_fn_e;

  // Next fetch address
  typedef enum logic [1:0] {
    pc_plus4,
    pc_branch,
    pc_jal
  } pc_sel_e;

  // Second operand source in decode
  typedef enum logic [1:0] {
    op2_rf,
    op2_imm,
    op2_mngr
  } op2_sel_e;

  typedef enum logic [1:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_j
  } imm_sel_e;

  localparam word_t c_reset_vector = 32'h0000_0200;

endpackage
